/* rtl/IntegrityPkg.sv */
// Integrity stage shared definitions
// Widths, chunk counts, MAC constants, command and state types

package IntegrityPkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------

	// Frontend and backend data beat
	localparam int DataWidth = 64;
	// Physical address (ORAMU)
	localparam int AddrWidth = 32;
	// Leaf label (ORAML)
	localparam int LeafWidth = 16;
	// Block counter (AESEntropy)
	localparam int CounterWidth = 64;

	// ----------------------------------------
	// Chunk counts
	// ----------------------------------------

	localparam int BlockChunks = 8;
	localparam int HeaderChunks = 2;
	localparam int MacChunks = 1;
	// Wide enough for every absorbed chunk of one store
	localparam int ChunkCountWidth = $clog2(HeaderChunks + BlockChunks + 1);

	// ----------------------------------------
	// MAC constants
	// ----------------------------------------

	// Initial digest, doubles as the key
	localparam logic [DataWidth-1:0] MacKey = 64'h5e7a_2a9d_4335_745b;
	// Odd, so the multiply is invertible mod 2^64
	localparam logic [DataWidth-1:0] MacMultiplier = 64'h9e37_79b9_7f4a_7c15;
	localparam int MacRotate = 13;

	// ----------------------------------------
	// Types
	// ----------------------------------------

	// Update and Append are the store commands
	typedef enum logic [1:0] {
		BeUpdate = 2'd0,
		BeAppend = 2'd1,
		BeRead = 2'd2,
		BeReadRemove = 2'd3
	} BackendCommand;

	// Store path sequencing
	typedef enum logic [2:0] {
		StIdle,
		StIssue,
		StHeader,
		StPayload,
		StFinish,
		StMac
	} VerifierState;

	// Full frontend command, 194 bits
	typedef struct packed {
		BackendCommand command;
		logic [AddrWidth-1:0] pAddr;
		logic [LeafWidth-1:0] currentLeaf;
		logic [LeafWidth-1:0] remappedLeaf;
		logic [CounterWidth-1:0] currentCounter;
		logic [CounterWidth-1:0] remappedCounter;
	} CommandEntry;

	// Request seen by the backend, 66 bits
	typedef struct packed {
		BackendCommand command;
		logic [AddrWidth-1:0] pAddr;
		logic [LeafWidth-1:0] currentLeaf;
		logic [LeafWidth-1:0] remappedLeaf;
	} BackendRequest;

endpackage

/* rtl/CommandQueue.sv */
// One-entry command register
// Decouples the frontend command handshake from the verifier FSM

`timescale 1ns/1ps

module CommandQueue
	import IntegrityPkg::*;
(
	input logic Clock,
	input logic reset,
	input CommandEntry inEntry,
	input logic inValid,
	output logic inReady,
	output CommandEntry outEntry,
	output logic outValid,
	input logic outReady
);

	// Occupancy of the single slot
	logic full;
	CommandEntry entry;

	// ----------------------------------------
	// Handshakes
	// ----------------------------------------

	// Only accept into an empty slot
	assign inReady = !full;
	assign outValid = full;
	assign outEntry = entry;

	// Fill on input transfer, drain on output transfer
	always_ff @(posedge Clock) begin
		if (reset) begin
			full <= 1'b0;
		end else if (inValid && inReady) begin
			full <= 1'b1;
		end else if (outValid && outReady) begin
			full <= 1'b0;
		end
	end

	// Payload, captured only when empty
	always_ff @(posedge Clock) begin
		if (inValid && inReady) begin
			entry <= inEntry;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// Offered entry holds steady under back-pressure
	assert property (@(posedge Clock) disable iff (reset)
		(outValid && !outReady) |=> (outValid && $stable(outEntry)));

endmodule

/* rtl/ChunkCounter.sv */
// Beat counter with a threshold
// Terminal flags the last beat of a phase, count wraps on it

`timescale 1ns/1ps

module ChunkCounter
	import IntegrityPkg::*;
#(
	parameter int Threshold = 1
) (
	input logic Clock,
	input logic reset,
	input logic enable,
	output logic [ChunkCountWidth-1:0] count,
	output logic terminal
);

	// Last beat of the phase
	assign terminal = enable && (count == ChunkCountWidth'(Threshold - 1));

	always_ff @(posedge Clock) begin
		if (reset) begin
			count <= '0;
		end else if (terminal) begin
			// Wrap, ready for the next store
			count <= '0;
		end else if (enable) begin
			count <= count + 1'b1;
		end
	end

	// Wrap keeps count below the threshold
	assert property (@(posedge Clock) disable iff (reset)
		count < ChunkCountWidth'(Threshold));

endmodule

/* rtl/MacEngine.sv */
// Keyed mixing MAC over 64-bit chunks
// Rotate, XOR, multiply per chunk; two-cycle finalization

`timescale 1ns/1ps

module MacEngine
	import IntegrityPkg::*;
(
	input logic Clock,
	input logic reset,
	input logic start,
	input logic absorbValid,
	output logic absorbReady,
	input logic [DataWidth-1:0] chunk,
	input logic finalize,
	output logic digestValid,
	input logic digestTaken,
	output logic [DataWidth-1:0] digest
);

	// Running state
	logic [DataWidth-1:0] state;
	// Chunks absorbed since start
	logic [ChunkCountWidth-1:0] chunkCount;
	// Second finalization step outstanding
	logic mixPending;

	// ----------------------------------------
	// Mixing step
	// ----------------------------------------

	function automatic logic [DataWidth-1:0] mixStep(
		input logic [DataWidth-1:0] current,
		input logic [DataWidth-1:0] data
	);
		logic [DataWidth-1:0] rotated;
		logic [DataWidth-1:0] mixed;
		// Rotate left by MacRotate
		rotated = {current[DataWidth-1-MacRotate:0], current[DataWidth-1:DataWidth-MacRotate]};
		mixed = rotated ^ data;
		// Product truncated to 64 bits, i.e. mod 2^64
		return mixed * MacMultiplier;
	endfunction

	// Busy only across the two finalization cycles
	assign absorbReady = !(finalize || mixPending);
	assign digest = state;

	// ----------------------------------------
	// Digest state
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= MacKey;
			chunkCount <= '0;
			mixPending <= 1'b0;
			digestValid <= 1'b0;
		end else begin
			// Consumer has the digest
			if (digestValid && digestTaken) begin
				digestValid <= 1'b0;
			end
			if (start) begin
				state <= MacKey;
				chunkCount <= '0;
				digestValid <= 1'b0;
			end else if (absorbValid && absorbReady) begin
				state <= mixStep(state, chunk);
				chunkCount <= chunkCount + 1'b1;
			end else if (finalize) begin
				// Length binding, then key addition
				state <= (state ^ DataWidth'(chunkCount)) + MacKey;
				mixPending <= 1'b1;
			end else if (mixPending) begin
				// Closing mix with a zero chunk
				state <= mixStep(state, '0);
				mixPending <= 1'b0;
				digestValid <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// No chunk offered while finalizing
	assert property (@(posedge Clock) disable iff (reset)
		absorbValid |-> absorbReady);

endmodule

/* rtl/IntegrityVerifier.sv */
// Integrity stage between ORAM frontend and backend
// Issues backend requests, appends a keyed MAC to stores, passes loads through

`timescale 1ns/1ps

module IntegrityVerifier
	import IntegrityPkg::*;
(
	input logic Clock,
	input logic reset,
	// Frontend
	input CommandEntry feCommand,
	input logic feCommandValid,
	output logic feCommandReady,
	output logic [DataWidth-1:0] feLoadData,
	output logic feLoadValid,
	input logic feLoadReady,
	input logic [DataWidth-1:0] feStoreData,
	input logic feStoreValid,
	output logic feStoreReady,
	// Backend
	output BackendRequest beCommand,
	output logic beCommandValid,
	input logic beCommandReady,
	input logic [DataWidth-1:0] beLoadData,
	input logic beLoadValid,
	output logic beLoadReady,
	output logic [DataWidth-1:0] beStoreData,
	output logic beStoreValid,
	input logic beStoreReady
);

	// ----------------------------------------
	// Signals
	// ----------------------------------------

	VerifierState state;
	VerifierState nextState;

	// Queued command
	CommandEntry queueEntry;
	logic queueValid;
	logic queueReady;

	logic isStore;
	logic commandTransfer;

	// Phase counters
	logic [ChunkCountWidth-1:0] headerCount;
	logic headerTerminal;
	logic payloadBeat;
	logic payloadTerminal;
	logic macBeat;
	logic macTerminal;

	// MAC engine side
	logic macStart;
	logic absorbValid;
	logic absorbReady;
	logic [DataWidth-1:0] headerChunk;
	logic [DataWidth-1:0] absorbChunk;
	logic macFinalize;
	logic digestValid;
	logic [DataWidth-1:0] digest;

	// ----------------------------------------
	// Command queue
	// ----------------------------------------

	CommandQueue commandQueue (
		.Clock(Clock),
		.reset(reset),
		.inEntry(feCommand),
		.inValid(feCommandValid),
		.inReady(feCommandReady),
		.outEntry(queueEntry),
		.outValid(queueValid),
		.outReady(queueReady)
	);

	assign isStore = (queueEntry.command == BeUpdate) || (queueEntry.command == BeAppend);

	// Request fields straight from the held entry
	always_comb begin
		beCommand.command = queueEntry.command;
		beCommand.pAddr = queueEntry.pAddr;
		beCommand.currentLeaf = queueEntry.currentLeaf;
		beCommand.remappedLeaf = queueEntry.remappedLeaf;
	end

	assign beCommandValid = (state == StIssue);
	assign commandTransfer = beCommandValid && beCommandReady;

	// Entry stays queued until the store finishes
	assign queueReady = (commandTransfer && !isStore) || macTerminal;

	// ----------------------------------------
	// FSM
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			state <= StIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			StIdle:
				if (queueValid) begin
					nextState = StIssue;
				end
			StIssue:
				if (commandTransfer) begin
					nextState = isStore ? StHeader : StIdle;
				end
			StHeader:
				if (headerTerminal) begin
					nextState = StPayload;
				end
			StPayload:
				if (payloadTerminal) begin
					nextState = StFinish;
				end
			StFinish:
				nextState = StMac;
			StMac:
				if (macTerminal) begin
					nextState = StIdle;
				end
			default:
				nextState = StIdle;
		endcase
	end

	// ----------------------------------------
	// Store path
	// ----------------------------------------

	// Counter is the first header chunk, pAddr the second
	assign headerChunk = (headerCount == '0) ? queueEntry.currentCounter
		: {{(DataWidth - AddrWidth){1'b0}}, queueEntry.pAddr};

	// One payload beat moves to backend and MAC together
	assign payloadBeat = (state == StPayload) && feStoreValid && beStoreReady && absorbReady;
	assign macBeat = (state == StMac) && digestValid && beStoreReady;

	assign feStoreReady = (state == StPayload) && beStoreReady && absorbReady;
	assign beStoreValid = ((state == StPayload) && feStoreValid && absorbReady)
		|| ((state == StMac) && digestValid);
	assign beStoreData = (state == StMac) ? digest : feStoreData;

	// Header counter drives the header mux
	ChunkCounter #(
		.Threshold(HeaderChunks)
	) headerCounter (
		.Clock(Clock),
		.reset(reset),
		.enable(state == StHeader && absorbReady),
		.count(headerCount),
		.terminal(headerTerminal)
	);

	ChunkCounter #(
		.Threshold(BlockChunks)
	) payloadCounter (
		.Clock(Clock),
		.reset(reset),
		.enable(payloadBeat),
		.count(),
		.terminal(payloadTerminal)
	);

	ChunkCounter #(
		.Threshold(MacChunks)
	) macCounter (
		.Clock(Clock),
		.reset(reset),
		.enable(macBeat),
		.count(),
		.terminal(macTerminal)
	);

	// ----------------------------------------
	// MAC engine
	// ----------------------------------------

	// Fresh digest for every store
	assign macStart = commandTransfer && isStore;
	assign absorbValid = (state == StHeader) || payloadBeat;
	assign absorbChunk = (state == StHeader) ? headerChunk : feStoreData;
	assign macFinalize = (state == StFinish);

	MacEngine macEngine (
		.Clock(Clock),
		.reset(reset),
		.start(macStart),
		.absorbValid(absorbValid),
		.absorbReady(absorbReady),
		.chunk(absorbChunk),
		.finalize(macFinalize),
		.digestValid(digestValid),
		.digestTaken(macBeat),
		.digest(digest)
	);

	// ----------------------------------------
	// Load path
	// ----------------------------------------

	// Loads go straight through with no MAC check
	assign feLoadData = beLoadData;
	assign feLoadValid = beLoadValid;
	assign beLoadReady = feLoadReady;

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// Frontend store beat only in payload, and forwarded to the backend in the same cycle
	assert property (@(posedge Clock) disable iff (reset)
		(feStoreValid && feStoreReady)
		|-> ((state == StPayload) && beStoreValid && beStoreReady));

endmodule

/* verification/IntegrityVerifierTb.sv */
// Self-checking testbench for the integrity stage
// Replays store and load vectors, models the MAC rule, checks the backend stream

`timescale 1ns/1ps

module IntegrityVerifierTb
	import IntegrityPkg::*;
;

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 16;
	localparam int CyclesPerVector = 40;
	localparam int RecordWords = 15;
	localparam int MaxRecords = 8;
	localparam int MaxWords = 1 + MaxRecords * RecordWords;
	localparam int LoadBeats = 4;
	// Offset of the first data word inside a record
	localparam int DataOffset = 7;

	logic Clock;
	logic reset;
	CommandEntry feCommand;
	logic feCommandValid;
	logic feCommandReady;
	logic [DataWidth-1:0] feLoadData;
	logic feLoadValid;
	logic feLoadReady;
	logic [DataWidth-1:0] feStoreData;
	logic feStoreValid;
	logic feStoreReady;
	BackendRequest beCommand;
	logic beCommandValid;
	logic beCommandReady;
	logic [DataWidth-1:0] beLoadData;
	logic beLoadValid;
	logic beLoadReady;
	logic [DataWidth-1:0] beStoreData;
	logic beStoreValid;
	logic beStoreReady;

	logic [63:0] vectorMem [0:MaxWords-1];
	int vectorCount;
	int requestErrors;
	int dataErrors;
	int macErrors;
	int otherErrors;

	IntegrityVerifier i_dut (.*);

	initial Clock = 1'b0;
	always #(ClockPeriod / 2) Clock = ~Clock;

	// ----------------------------------------
	// Vector access and reference model
	// ----------------------------------------

	function automatic logic [63:0] vectorWord(input int record, input int offset);
		return vectorMem[1 + record * RecordWords + offset];
	endfunction

	function automatic CommandEntry recordEntry(input int record);
		CommandEntry e;
		logic [63:0] raw;
		raw = vectorWord(record, 1);
		e.command = BackendCommand'(raw[1:0]);
		e.pAddr = AddrWidth'(vectorWord(record, 2));
		e.currentLeaf = LeafWidth'(vectorWord(record, 3));
		e.remappedLeaf = LeafWidth'(vectorWord(record, 4));
		e.currentCounter = vectorWord(record, 5);
		e.remappedCounter = vectorWord(record, 6);
		return e;
	endfunction

	function automatic BackendRequest requestOf(input CommandEntry e);
		BackendRequest r;
		r.command = e.command;
		r.pAddr = e.pAddr;
		r.currentLeaf = e.currentLeaf;
		r.remappedLeaf = e.remappedLeaf;
		return r;
	endfunction

	// Rotate left, XOR chunk, multiply mod 2^64
	function automatic logic [63:0] mixChunk(input logic [63:0] d, input logic [63:0] c);
		logic [63:0] rot;
		rot = (d << MacRotate) | (d >> (64 - MacRotate));
		return (rot ^ c) * MacMultiplier;
	endfunction

	// Header (counter, address) then block, then finalization
	function automatic logic [63:0] referenceMac(input int record);
		CommandEntry e;
		logic [63:0] d;
		e = recordEntry(record);
		d = MacKey;
		d = mixChunk(d, e.currentCounter);
		d = mixChunk(d, {32'b0, e.pAddr});
		for (int i = 0; i < BlockChunks; i++) begin
			d = mixChunk(d, vectorWord(record, DataOffset + i));
		end
		d = d ^ 64'(HeaderChunks + BlockChunks);
		d = d + MacKey;
		return mixChunk(d, 64'd0);
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------

	task automatic compareRequest(input BackendRequest got, input BackendRequest expected);
		if (got !== expected) begin
			requestErrors++;
			$display("Error at %0t: backend request %h, expected %h", $time, got, expected);
		end
	endtask

	task automatic compareBeat(input logic [DataWidth-1:0] got,
		input logic [DataWidth-1:0] expected, input string what);
		if (got !== expected) begin
			dataErrors++;
			$display("Error at %0t: %s %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic compareMac(input logic [DataWidth-1:0] got,
		input logic [DataWidth-1:0] expected);
		if (got !== expected) begin
			macErrors++;
			$display("Error at %0t: MAC beat %h, expected %h", $time, got, expected);
		end
	endtask

	task automatic checkIdleOutputs();
		if (beCommandValid !== 1'b0 || beStoreValid !== 1'b0 || feStoreReady !== 1'b0
			|| feCommandReady !== 1'b1) begin
			otherErrors++;
			$display("Error at %0t: outputs are not in their reset values", $time);
		end
	endtask

	// ----------------------------------------
	// Frontend and backend agents
	// ----------------------------------------

	task automatic sendCommand(input CommandEntry e);
		@(posedge Clock);
		feCommand <= e;
		feCommandValid <= 1'b1;
		@(negedge Clock);
		while (!feCommandReady) @(negedge Clock);
		@(posedge Clock);
		feCommandValid <= 1'b0;
	endtask

	task automatic acceptRequest(input BackendRequest expected);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(posedge Clock);
			beCommandReady <= ($urandom % 3) != 0;
			@(negedge Clock);
			if (beCommandValid && beCommandReady) begin
				compareRequest(beCommand, expected);
				done = 1'b1;
			end
		end
		@(posedge Clock);
		beCommandReady <= 1'b0;
	endtask

	task automatic feedStore(input int record);
		for (int i = 0; i < BlockChunks; i++) begin
			@(posedge Clock);
			feStoreData <= vectorWord(record, DataOffset + i);
			feStoreValid <= 1'b1;
			@(negedge Clock);
			while (!feStoreReady) @(negedge Clock);
		end
		@(posedge Clock);
		feStoreValid <= 1'b0;
	endtask

	// Eight block beats, then the MAC beat
	task automatic collectStore(input int record);
		int beats;
		logic [63:0] expectedMac;
		beats = 0;
		expectedMac = referenceMac(record);
		while (beats < BlockChunks + MacChunks) begin
			@(posedge Clock);
			beStoreReady <= ($urandom % 4) != 0;
			@(negedge Clock);
			if (beStoreValid && beStoreReady) begin
				if (beats < BlockChunks) begin
					compareBeat(beStoreData, vectorWord(record, DataOffset + beats), "store beat");
				end else begin
					compareMac(beStoreData, expectedMac);
				end
				beats++;
			end
		end
		@(posedge Clock);
		beStoreReady <= 1'b0;
	endtask

	task automatic driveLoad(input int record);
		for (int i = 0; i < LoadBeats; i++) begin
			@(posedge Clock);
			beLoadData <= vectorWord(record, DataOffset + i);
			beLoadValid <= 1'b1;
			@(negedge Clock);
			while (!beLoadReady) @(negedge Clock);
		end
		@(posedge Clock);
		beLoadValid <= 1'b0;
	endtask

	task automatic checkLoad(input int record);
		int beats;
		beats = 0;
		while (beats < LoadBeats) begin
			@(posedge Clock);
			feLoadReady <= ($urandom % 3) != 0;
			@(negedge Clock);
			if (beLoadReady !== feLoadReady) begin
				otherErrors++;
				$display("Error at %0t: beLoadReady does not follow feLoadReady", $time);
			end
			if (feLoadValid !== beLoadValid) begin
				otherErrors++;
				$display("Error at %0t: feLoadValid does not follow beLoadValid", $time);
			end
			if (feLoadValid && feLoadReady) begin
				compareBeat(feLoadData, vectorWord(record, DataOffset + beats), "load beat");
				beats++;
			end
		end
		@(posedge Clock);
		feLoadReady <= 1'b0;
	endtask

	task automatic runRecord(input int record);
		CommandEntry e;
		e = recordEntry(record);
		fork
			sendCommand(e);
			acceptRequest(requestOf(e));
			if (vectorWord(record, 0) == 64'd0) begin
				fork
					feedStore(record);
					collectStore(record);
				join
			end else begin
				fork
					driveLoad(record);
					checkLoad(record);
				join
			end
		join
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		reset = 1'b1;
		feCommand = '0;
		feCommandValid = 1'b0;
		feLoadReady = 1'b0;
		feStoreData = '0;
		feStoreValid = 1'b0;
		beCommandReady = 1'b0;
		beLoadData = '0;
		beLoadValid = 1'b0;
		beStoreReady = 1'b0;
		requestErrors = 0;
		dataErrors = 0;
		macErrors = 0;
		otherErrors = 0;
		void'($urandom(3));
		$readmemh("verification/store_vectors.txt", vectorMem);
		vectorCount = int'(vectorMem[0]);
		if (vectorCount < 1 || vectorCount > MaxRecords) begin
			otherErrors++;
			$display("The vector file is missing or holds a bad record count");
			vectorCount = 0;
		end
		@(posedge Clock);
		repeat (ResetCycles - 1) begin
			@(negedge Clock);
			checkIdleOutputs();
			@(posedge Clock);
		end
		reset <= 1'b0;
		// First cycle out of reset
		@(negedge Clock);
		checkIdleOutputs();
		for (int r = 0; r < vectorCount; r++) begin
			runRecord(r);
		end
		repeat (2) @(posedge Clock);
		$display("Errors: request %0d, data %0d, MAC %0d, other %0d",
			requestErrors, dataErrors, macErrors, otherErrors);
		if (requestErrors + dataErrors + macErrors + otherErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the vector count
	initial begin
		#1;
		#((vectorCount * CyclesPerVector + ResetCycles) * ClockPeriod);
		$display("The run did not finish in time, watchdog stopped it");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* verification/store_vectors.txt */
// Record count, then records of 15 hex words each:
// kind (0 store, 1 load), command, pAddr, currentLeaf, remappedLeaf, currentCounter,
// remappedCounter, then eight data words (loads use the first four)
6
// Update
0 0 00001a40 0123 0456 0000000000000001 0000000000000002
1111111111111111 2222222222222222 3333333333333333 4444444444444444
5555555555555555 6666666666666666 7777777777777777 8888888888888888
// Read
1 2 00001a40 0123 0789 0000000000000002 0000000000000003
0123456789abcdef fedcba9876543210 0f0f0f0f0f0f0f0f f0f0f0f0f0f0f0f0
0000000000000000 0000000000000000 0000000000000000 0000000000000000
// Append
0 1 7ffff000 ffff 0001 00000000deadbeef 00000000deadbef0
0000000000000000 ffffffffffffffff 8000000000000001 0000000100000000
a5a5a5a5a5a5a5a5 5a5a5a5a5a5a5a5a 00000000000000ff ff00000000000000
// Update
0 0 00000004 0002 0003 ffffffffffffffff 0000000000000000
cafef00dcafef00d 0badc0de0badc0de 1357924680ace135 2468ace013579bdf
0000000000000001 0000000000000002 0000000000000003 0000000000000004
// ReadRemove
1 3 00000004 0003 0010 0000000000000000 0000000000000001
aaaaaaaaaaaaaaaa bbbbbbbbbbbbbbbb cccccccccccccccc dddddddddddddddd
0000000000000000 0000000000000000 0000000000000000 0000000000000000
// Append
0 1 12345678 4321 8765 0102030405060708 0102030405060709
0f1e2d3c4b5a6978 8796a5b4c3d2e1f0 0011223344556677 8899aabbccddeeff
1020304050607080 90a0b0c0d0e0f000 0000000000000000 7fffffffffffffff

/* all.f */
rtl/IntegrityPkg.sv
rtl/CommandQueue.sv
rtl/ChunkCounter.sv
rtl/MacEngine.sv
rtl/IntegrityVerifier.sv
verification/IntegrityVerifierTb.sv

/* Bender.yml */
package:
  name: integrity_verifier

sources:
  - files:
      - rtl/IntegrityPkg.sv
      - rtl/CommandQueue.sv
      - rtl/ChunkCounter.sv
      - rtl/MacEngine.sv
      - rtl/IntegrityVerifier.sv
  - target: test
    files:
      - verification/IntegrityVerifierTb.sv
